// ==== conv_pkg.sv ====
package conv_pkg;

    // kernel geometry and datapath widths for the first LeNet conv layer.
    localparam int kernel_size    = 5;
    localparam int data_width     = 8;
    localparam int prod_width     = 16;

    // five 16-bit products need three more bits, and five row sums two more.
    localparam int row_sum_width  = 19;
    localparam int sum_width      = 21;

    localparam int row_addr_width = 3;

    // command opcodes carried on cmd_op with every cmd_valid strobe.
    typedef enum logic [1:0] {
        op_nop          = 2'b00,
        op_load_weights = 2'b01,
        op_push_row     = 2'b10,
        op_clear        = 2'b11
    } conv_op_t;

    // tracks whether the current window has received any row yet.
    typedef enum logic {
        win_empty   = 1'b0,
        win_filling = 1'b1
    } win_state_t;

endpackage

// ==== row_if.sv ====
`timescale 1ns/1ps

interface row_if;
    import conv_pkg::*;

    logic                              step;
    logic [row_addr_width-1:0]         row_sel;
    logic                              first_row;
    logic                              last_row;
    logic [kernel_size*data_width-1:0] pixels;

    modport ctrl (
        output step,
        output row_sel,
        output first_row,
        output last_row,
        output pixels
    );

    modport bank (
        input row_sel
    );

    modport mac (
        input step,
        input first_row,
        input last_row,
        input pixels
    );

    modport accum (
        input step,
        input first_row,
        input last_row
    );

endinterface

// ==== lenet_xfyw_5.sv ====
`timescale 1ns/1ps

module lenet_xfyw_5 (
    input  logic [7:0]  x,
    input  logic [7:0]  y,
    output logic [15:0] z
);

    logic [7:0]  pp [8];
    logic [12:0] c1;
    logic [12:0] c2;
    logic [12:0] c3;
    logic        c4;
    logic        c5;
    logic        c6;

    // one partial product row per bit of x.
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // the lower six partial products are replaced by fixed compressor terms.
    // only rows 6 and 7 of the array survive in full.
    always_comb begin
        c1     = '0;
        c1[4]  = pp[2][2] & pp[3][1];
        c1[5]  = pp[0][4] & pp[1][3];
        c1[6]  = pp[0][5] | pp[1][4];
        c1[7]  = pp[0][6] | pp[1][5];
        c1[8]  = pp[1][7];
        c1[9]  = pp[2][7] | pp[3][6];
        c1[10] = pp[3][7];
        c1[11] = pp[4][6] & pp[5][5];
        c1[12] = pp[5][7];
    end

    always_comb begin
        c2     = '0;
        c2[5]  = pp[0][5] & pp[1][4];
        c2[6]  = pp[2][3] | pp[3][2];
        c2[7]  = pp[0][7] | pp[1][6];
        c2[8]  = pp[2][5] & pp[3][4];
        c2[9]  = pp[4][5] & pp[5][4];
        c2[10] = pp[4][6] ^ pp[5][5];
        c2[11] = pp[4][7] & pp[5][6];
    end

    always_comb begin
        c3     = '0;
        c3[7]  = pp[2][5] ^ pp[3][4];
        c3[8]  = pp[2][6] & pp[3][5];
        c3[9]  = pp[4][5] | pp[5][4];
        c3[11] = pp[4][7] | pp[5][6];
    end

    // three single-bit terms that all land on weight 256.
    assign c4 = pp[2][6] | pp[3][5];
    assign c5 = pp[4][3] | pp[5][2];
    assign c6 = pp[4][4] | pp[5][3];

    assign z = {2'b00, pp[6], 6'b0}
             + {1'b0, pp[7], 7'b0}
             + {3'b000, c1}
             + {3'b000, c2}
             + {3'b000, c3}
             + {7'b0, c4, 8'b0}
             + {7'b0, c5, 8'b0}
             + {7'b0, c6, 8'b0};

endmodule

// ==== weight_bank.sv ====
`timescale 1ns/1ps

module weight_bank (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                wr_en,
    input  logic [conv_pkg::row_addr_width-1:0]                 wr_row,
    input  logic [conv_pkg::kernel_size*conv_pkg::data_width-1:0] wr_data,
    row_if.bank                                                 rif,
    output logic [conv_pkg::kernel_size*conv_pkg::data_width-1:0] weights
);
    import conv_pkg::*;

    logic [kernel_size*data_width-1:0] rows [kernel_size];

    // weights start at zero so rows pushed before any load sum to zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < kernel_size; r++) begin
                rows[r] <= '0;
            end
        end else if (wr_en && (wr_row < kernel_size)) begin
            rows[wr_row] <= wr_data;
        end
    end

    // combinational read so the row lines up with the pixels on step.
    assign weights = rows[rif.row_sel];

endmodule

// ==== row_mac.sv ====
`timescale 1ns/1ps

module row_mac (
    input  logic                                                clk,
    input  logic                                                reset,
    row_if.mac                                                  rif,
    input  logic [conv_pkg::kernel_size*conv_pkg::data_width-1:0] weights,
    output logic                                                row_valid,
    output logic                                                row_first,
    output logic                                                row_last,
    output logic [conv_pkg::row_sum_width-1:0]                  row_sum
);
    import conv_pkg::*;

    logic [prod_width-1:0]    prod [kernel_size];
    logic [prod_width:0]      sum_01;
    logic [prod_width:0]      sum_23;
    logic [prod_width+1:0]    sum_0123;
    logic [row_sum_width-1:0] sum_row;

    // the weight drives x and the pixel drives y.
    for (genvar k = 0; k < kernel_size; k++) begin : g_mul
        lenet_xfyw_5 u_mul (
            .x (weights[k*data_width +: data_width]),
            .y (rif.pixels[k*data_width +: data_width]),
            .z (prod[k])
        );
    end

    assign sum_01   = {1'b0, prod[0]} + {1'b0, prod[1]};
    assign sum_23   = {1'b0, prod[2]} + {1'b0, prod[3]};
    assign sum_0123 = {1'b0, sum_01} + {1'b0, sum_23};
    assign sum_row  = {1'b0, sum_0123} + {3'b000, prod[4]};

    always_ff @(posedge clk) begin
        if (reset) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= rif.step;
        end
    end

    // markers and sum are only meaningful while row_valid is high.
    always_ff @(posedge clk) begin
        if (rif.step) begin
            row_sum   <= sum_row;
            row_first <= rif.first_row;
            row_last  <= rif.last_row;
        end
    end

endmodule

// ==== window_accum.sv ====
`timescale 1ns/1ps

module window_accum (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               row_valid,
    input  logic                               row_first,
    input  logic                               row_last,
    input  logic [conv_pkg::row_sum_width-1:0] row_sum,
    output logic                               sum_valid,
    output logic [conv_pkg::sum_width-1:0]     sum
);
    import conv_pkg::*;

    logic [sum_width-1:0] acc;
    logic [sum_width-1:0] acc_next;

    // a first row restarts the total, so windows can run back to back.
    // the sum wraps at 21 bits.
    assign acc_next = row_first
                    ? {{(sum_width-row_sum_width){1'b0}}, row_sum}
                    : acc + {{(sum_width-row_sum_width){1'b0}}, row_sum};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= row_valid && row_last;
            if (row_valid) begin
                acc <= acc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid && row_last) begin
            sum <= acc_next;
        end
    end

endmodule

// ==== conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                cmd_valid,
    input  conv_pkg::conv_op_t                                  cmd_op,
    input  logic [conv_pkg::row_addr_width-1:0]                 cmd_row,
    input  logic [conv_pkg::kernel_size*conv_pkg::data_width-1:0] cmd_data,
    output logic                                                wr_en,
    output logic [conv_pkg::row_addr_width-1:0]                 wr_row,
    output logic [conv_pkg::kernel_size*conv_pkg::data_width-1:0] wr_data,
    row_if.ctrl                                                 rif
);
    import conv_pkg::*;

    win_state_t                state;
    logic [row_addr_width-1:0] row_cnt;
    logic                      push;
    logic                      clear;
    logic                      at_last;

    // weight writes go straight to the bank and land on this edge.
    assign wr_en   = cmd_valid && (cmd_op == op_load_weights);
    assign wr_row  = cmd_row;
    assign wr_data = cmd_data;

    assign push    = cmd_valid && (cmd_op == op_push_row);
    assign clear   = cmd_valid && (cmd_op == op_clear);
    assign at_last = (row_cnt == row_addr_width'(kernel_size - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= win_empty;
            row_cnt     <= '0;
            rif.step    <= 1'b0;
            rif.row_sel <= '0;
        end else begin
            rif.step <= push;
            if (clear) begin
                state   <= win_empty;
                row_cnt <= '0;
            end else if (push) begin
                rif.row_sel <= row_cnt;
                if (at_last) begin
                    state   <= win_empty;
                    row_cnt <= '0;
                end else begin
                    state   <= win_filling;
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            rif.pixels    <= cmd_data;
            rif.first_row <= (state == win_empty);
            rif.last_row  <= at_last;
        end
    end

endmodule

// ==== conv5_engine.sv ====
`timescale 1ns/1ps

module conv5_engine (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                cmd_valid,
    input  conv_pkg::conv_op_t                                  cmd_op,
    input  logic [conv_pkg::row_addr_width-1:0]                 cmd_row,
    input  logic [conv_pkg::kernel_size*conv_pkg::data_width-1:0] cmd_data,
    output logic                                                sum_valid,
    output logic [conv_pkg::sum_width-1:0]                      sum
);
    import conv_pkg::*;

    logic                              wr_en;
    logic [row_addr_width-1:0]         wr_row;
    logic [kernel_size*data_width-1:0] wr_data;
    logic [kernel_size*data_width-1:0] weights;
    logic                              row_valid;
    logic                              row_first;
    logic                              row_last;
    logic [row_sum_width-1:0]          row_sum;

    row_if rif ();

    conv_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_row   (cmd_row),
        .cmd_data  (cmd_data),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_data   (wr_data),
        .rif       (rif.ctrl)
    );

    weight_bank u_bank (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .rif     (rif.bank),
        .weights (weights)
    );

    row_mac u_mac (
        .clk       (clk),
        .reset     (reset),
        .rif       (rif.mac),
        .weights   (weights),
        .row_valid (row_valid),
        .row_first (row_first),
        .row_last  (row_last),
        .row_sum   (row_sum)
    );

    window_accum u_accum (
        .clk       (clk),
        .reset     (reset),
        .row_valid (row_valid),
        .row_first (row_first),
        .row_last  (row_last),
        .row_sum   (row_sum),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam time half_period = 20ns;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

// ==== tb_conv5.sv ====
`timescale 1ns/1ps

module tb_conv5;
    import conv_pkg::*;

    // about 60 windows of at most ten cycles each, plus weight loads and margin.
    localparam int max_cycles = 8000;
    localparam int unsigned sum_limit = 2 ** sum_width;
    localparam int unsigned approx_margin = 49146;

    logic                              clk;
    logic                              reset;
    logic                              cmd_valid;
    conv_op_t                          cmd_op;
    logic [row_addr_width-1:0]         cmd_row;
    logic [kernel_size*data_width-1:0] cmd_data;
    logic                              sum_valid;
    logic [sum_width-1:0]              sum;

    logic [31:0]                       rng_state;
    logic [7:0]                        w_model [kernel_size][kernel_size];
    logic [kernel_size*data_width-1:0] win_pix [kernel_size];
    int unsigned                       exp_lo [$];
    int unsigned                       exp_hi [$];
    int unsigned                       cur_lo;
    int unsigned                       cur_hi;
    int                                value_errors;
    int                                timing_errors;
    int                                other_errors;
    int                                cycle_count;
    int                                expected_row_cnt;
    logic                              fifth_push;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    conv5_engine UUT (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_row   (cmd_row),
        .cmd_data  (cmd_data),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [kernel_size*data_width-1:0] random_row(input logic [7:0] mask);
        logic [kernel_size*data_width-1:0] row;
        for (int k = 0; k < kernel_size; k++) begin
            row[k*data_width +: data_width] = next_random() & mask;
        end
        return row;
    endfunction

    // a term with zero weight low bits is exact, otherwise only the top two
    // weight bits pass exactly and the rest adds at most approx_margin.
    function automatic void window_bounds(output int unsigned lo, output int unsigned hi);
        int unsigned w;
        int unsigned p;
        lo = 0;
        hi = 0;
        for (int r = 0; r < kernel_size; r++) begin
            for (int k = 0; k < kernel_size; k++) begin
                w = w_model[r][k];
                p = win_pix[r][k*data_width +: data_width];
                if (w % 64 == 0) begin
                    lo += w * p;
                    hi += w * p;
                end else begin
                    lo += (w / 64) * 64 * p;
                    hi += (w / 64) * 64 * p + ((p == 0) ? 0 : approx_margin);
                end
            end
        end
    endfunction

    task automatic send_cmd(input conv_op_t op, input int row,
                            input logic [kernel_size*data_width-1:0] data);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_row   = row[row_addr_width-1:0];
        cmd_data  = data;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            cmd_op    = op_nop;
        end
    endtask

    task automatic load_weight_row(input int row, input logic [kernel_size*data_width-1:0] data);
        for (int k = 0; k < kernel_size; k++) begin
            w_model[row][k] = data[k*data_width +: data_width];
        end
        send_cmd(op_load_weights, row, data);
    endtask

    task automatic load_all_weights(input logic [7:0] mask);
        for (int r = 0; r < kernel_size; r++) begin
            load_weight_row(r, random_row(mask));
        end
        idle_cycles(1);
    endtask

    task automatic randomize_pixels();
        for (int r = 0; r < kernel_size; r++) begin
            win_pix[r] = random_row(8'hff);
        end
    endtask

    task automatic push_window(input int gap);
        int unsigned lo;
        int unsigned hi;
        window_bounds(lo, hi);
        if (hi >= sum_limit) begin
            other_errors++;
            $display("test setup error at %0t: window bound %0d does not fit in the sum",
                     $time, hi);
        end
        exp_lo.push_back(lo);
        exp_hi.push_back(hi);
        for (int r = 0; r < kernel_size; r++) begin
            send_cmd(op_push_row, 0, win_pix[r]);
            if (gap > 0) begin
                idle_cycles(gap);
            end
        end
    endtask

    task automatic push_rows_then_clear(input int rows);
        for (int r = 0; r < rows; r++) begin
            send_cmd(op_push_row, 0, win_pix[r]);
        end
        send_cmd(op_clear, 0, '0);
        idle_cycles(1);
    endtask

    // reference row count, taken from the command rules.
    always @(posedge clk) begin
        if (reset) begin
            expected_row_cnt <= 0;
        end else if (cmd_valid && cmd_op == op_clear) begin
            expected_row_cnt <= 0;
        end else if (cmd_valid && cmd_op == op_push_row) begin
            expected_row_cnt <= (expected_row_cnt == kernel_size - 1) ? 0 : expected_row_cnt + 1;
        end
    end

    assign fifth_push = cmd_valid && (cmd_op == op_push_row)
                     && (expected_row_cnt == kernel_size - 1);

    a_sum_after_push: assert property (@(posedge clk) disable iff (reset)
        fifth_push |-> ##3 sum_valid)
    else begin
        timing_errors++;
        $display("sum_valid did not follow the fifth pushed row in time at %0t", $time);
    end

    a_sum_needs_push: assert property (@(posedge clk) disable iff (reset)
        sum_valid |-> $past(fifth_push, 3))
    else begin
        timing_errors++;
        $display("sum_valid rose without a completed window at %0t", $time);
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (reset)
        sum_valid |=> !sum_valid)
    else begin
        timing_errors++;
        $display("sum_valid stayed high for more than one cycle at %0t", $time);
    end

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (!reset && sum_valid) begin
            if (exp_lo.size() == 0) begin
                other_errors++;
                $display("a sum arrived at %0t while no window was pending", $time);
            end else begin
                cur_lo = exp_lo.pop_front();
                cur_hi = exp_hi.pop_front();
                a_sum_value: assert ((sum >= cur_lo) && (sum <= cur_hi))
                else begin
                    value_errors++;
                    $display("[FAIL] t=%0t sum expected=%0d..%0d actual=%0d",
                             $time, cur_lo, cur_hi, sum);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        rng_state     = 32'h44cc_3a01;
        value_errors  = 0;
        timing_errors = 0;
        other_errors  = 0;
        cycle_count   = 0;
        for (int r = 0; r < kernel_size; r++) begin
            for (int k = 0; k < kernel_size; k++) begin
                w_model[r][k] = 8'd0;
            end
        end
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = op_nop;
        cmd_row   = '0;
        cmd_data  = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        a_reset_low: assert (sum_valid == 1'b0)
        else begin
            value_errors++;
            $display("[FAIL] t=%0t sum_valid expected=0 actual=%0b", $time, sum_valid);
        end
        idle_cycles(10);

        // weights are still zero, so the first window must sum to zero.
        randomize_pixels();
        push_window(0);
        idle_cycles(5);

        // exact weights with gaps between the rows.
        load_all_weights(8'hc0);
        repeat (10) begin
            randomize_pixels();
            push_window(1);
        end
        idle_cycles(5);

        // back-to-back windows.
        repeat (20) begin
            randomize_pixels();
            push_window(0);
        end
        idle_cycles(5);

        // bit 6 is cleared so the upper bound cannot wrap.
        load_all_weights(8'hbf);
        repeat (20) begin
            randomize_pixels();
            push_window(0);
        end
        idle_cycles(5);

        load_all_weights(8'hc0);
        randomize_pixels();
        push_rows_then_clear(2);
        push_window(0);
        idle_cycles(2);
        push_rows_then_clear(3);
        push_window(0);
        idle_cycles(5);

        // same pixels before and after a single row reload.
        randomize_pixels();
        push_window(0);
        idle_cycles(3);
        load_weight_row(2, random_row(8'hc0));
        idle_cycles(1);
        push_window(0);
        idle_cycles(1);

        while (exp_lo.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(5);

        $display("errors: value=%0d timing=%0d other=%0d",
                 value_errors, timing_errors, other_errors);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
conv_pkg.sv
row_if.sv
lenet_xfyw_5.sv
weight_bank.sv
row_mac.sv
window_accum.sv
conv_ctrl.sv
conv5_engine.sv
tb_clock_gen.sv
tb_conv5.sv

// ==== Bender.yml ====
package:
  name: conv5_engine

sources:
  - conv_pkg.sv
  - row_if.sv
  - lenet_xfyw_5.sv
  - weight_bank.sv
  - row_mac.sv
  - window_accum.sv
  - conv_ctrl.sv
  - conv5_engine.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_conv5.sv
